// File: logic/memctl_pkg.sv
// memory controller shared definitions
// widths, state encodings and the boot image word rule
// used by the ROM table and by the testbench model

package memctl_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int ADDR_BITS = 8;
	localparam int DATA_BITS = 8;

	typedef logic [ADDR_BITS - 1 : 0] addr_t;
	typedef logic [DATA_BITS - 1 : 0] data_t;

	// ----------------------------------------
	// state encodings
	// ----------------------------------------
	// overall board state
	typedef enum logic [1 : 0] {
		BOOT_RESET,
		BOOT_COPY,
		BOOT_RUN
	} boot_state_t;

	// processor memory access state
	typedef enum logic [1 : 0] {
		ACC_IDLE,
		ACC_READ_WAIT,
		ACC_WRITE_PREP,
		ACC_WRITE
	} access_state_t;

	// ----------------------------------------
	// boot image rule
	// ----------------------------------------
	// word = (addr xor a5) + 3, wrapping at the word width
	function automatic data_t boot_image_word(input addr_t addr);
		return data_t'(addr ^ 8'ha5) + data_t'(3);
	endfunction

endpackage

// File: logic/boot_rom.sv
// boot ROM
// combinational table of the boot image, one word per address
// only the low address bits select a word

module boot_rom import memctl_pkg::*; #(
	parameter int unsigned ROM_WORDS = 64
) (
	input  addr_t rom_addr,
	output data_t rom_data
);

	// index width, at least one bit
	localparam int ROM_BITS = (ROM_WORDS < 2) ? 1 : $clog2(ROM_WORDS);

	// table contents
	data_t rom_table [ROM_WORDS];

	// fill each entry from the image rule
	for (genvar i = 0; i < ROM_WORDS; i++) begin : g_word
		assign rom_table[i] = boot_image_word(addr_t'(i));
	end

	// ----------------------------------------
	// lookup
	// ----------------------------------------
	// word shows up in the same cycle as the address
	assign rom_data = rom_table[rom_addr[ROM_BITS - 1 : 0]];

endmodule

// File: logic/sys_ram.sv
// system RAM
// single port, synchronous write, registered read
// read returns the old word when read and write hit the same address

module sys_ram import memctl_pkg::*; (
	input  logic  clock,
	input  logic  ram_we,
	input  addr_t ram_addr,
	input  data_t ram_wdata,
	output data_t ram_rdata
);

	// one word per address
	localparam int RAM_WORDS = 2 ** ADDR_BITS;

	// storage array
	data_t mem [RAM_WORDS];

	// ----------------------------------------
	// write port
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
		end
	end

	// ----------------------------------------
	// read port
	// ----------------------------------------
	// data follows the address by one cycle
	always_ff @(posedge clock) begin
		ram_rdata <= mem[ram_addr];
	end

endmodule

// File: logic/rom_copier.sv
// ROM to RAM copier
// walks the boot ROM one address per cycle and
// hands each word on as a RAM write, then flags completion

module rom_copier import memctl_pkg::*; #(
	parameter int unsigned ROM_WORDS = 64
) (
	input  logic  clock,
	input  logic  copy_reset,
	output addr_t rom_addr,
	input  data_t rom_data,
	output logic  copy_we,
	output addr_t copy_addr,
	output data_t copy_data,
	output logic  copy_done
);

	// one extra bit so the count can reach ROM_WORDS
	localparam int CNT_BITS = $clog2(ROM_WORDS) + 1;

	logic [CNT_BITS - 1 : 0] copy_count;
	logic                    copy_last;

	// all words fetched
	assign copy_last = (copy_count == CNT_BITS'(ROM_WORDS));

	// current fetch address
	assign rom_addr = addr_t'(copy_count);

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (copy_reset) begin
			copy_count <= '0;
			copy_we    <= 1'b0;
			copy_done  <= 1'b0;
		end else if (!copy_last) begin
			// one word per cycle
			copy_count <= copy_count + 1'b1;
			copy_we    <= 1'b1;
		end else begin
			// last write leaves this cycle, done sticks
			copy_we   <= 1'b0;
			copy_done <= 1'b1;
		end
	end

	// ----------------------------------------
	// payload
	// ----------------------------------------
	// word and address registered together
	always_ff @(posedge clock) begin
		if (!copy_last) begin
			copy_addr <= rom_addr;
			copy_data <= rom_data;
		end
	end

	// no further writes once the copy has finished
	a_no_write_after_done : assert property (
		@(posedge clock) disable iff (copy_reset)
		copy_done |=> !copy_we
	);

endmodule

// File: logic/wait_counter.sv
// wait state counter
// counts cycles while a read or a write phase is held
// and flags the last wait cycle of the active kind

module wait_counter #(
	parameter int unsigned READ_WAIT  = 1,
	parameter int unsigned WRITE_WAIT = 2
) (
	input  logic clock,
	input  logic reset,
	input  logic count_read,
	input  logic count_write,
	output logic wait_done
);

	// counter sized for the longer wait
	localparam int MAX_WAIT = (READ_WAIT > WRITE_WAIT) ? READ_WAIT : WRITE_WAIT;
	localparam int CNT_BITS = (MAX_WAIT < 2) ? 1 : $clog2(MAX_WAIT + 1);

	logic [CNT_BITS - 1 : 0] wait_count;

	// limit reached for whichever phase is held
	assign wait_done = (count_read  && (wait_count == CNT_BITS'(READ_WAIT))) ||
		(count_write && (wait_count == CNT_BITS'(WRITE_WAIT)));

	// ----------------------------------------
	// counter
	// ----------------------------------------
	// clears when idle or at the limit, so a read phase
	// straight after a write phase starts from zero
	always_ff @(posedge clock) begin
		if (reset) begin
			wait_count <= '0;
		end else if (wait_done || !(count_read || count_write)) begin
			wait_count <= '0;
		end else begin
			wait_count <= wait_count + 1'b1;
		end
	end

	// the sequencer runs one phase at a time
	a_one_phase : assert property (
		@(posedge clock) disable iff (reset)
		!(count_read && count_write)
	);

endmodule

// File: logic/mem_sequencer.sv
// memory sequencer
// boot state machine, processor access state machine,
// RAM port steering and the watched address register

module mem_sequencer import memctl_pkg::*; #(
	parameter addr_t WATCH_ADDR = 8'hff
) (
	input  logic  clock,
	input  logic  reset,
	// copier side
	output logic  copy_reset,
	input  logic  copy_we,
	input  addr_t copy_addr,
	input  data_t copy_data,
	input  logic  copy_done,
	// processor side
	input  logic  mem_valid,
	input  logic  mem_write,
	input  addr_t mem_addr,
	input  data_t mem_wdata,
	output logic  mem_ready,
	// RAM port
	output logic  ram_we,
	output addr_t ram_addr,
	output data_t ram_wdata,
	// wait states
	output logic  count_read,
	output logic  count_write,
	input  logic  wait_done,
	// status
	output logic  booting,
	output logic  running,
	output data_t watch_data
);

	boot_state_t   boot_state;
	boot_state_t   boot_next;
	access_state_t acc_state;
	access_state_t acc_next;

	// latched processor write word
	data_t write_data;

	// ----------------------------------------
	// boot state machine
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			boot_state <= BOOT_RESET;
		end else begin
			boot_state <= boot_next;
		end
	end

	always_comb begin
		boot_next = boot_state;
		case (boot_state)
			// single cycle, clears the copier
			BOOT_RESET: boot_next = BOOT_COPY;
			BOOT_COPY: begin
				if (copy_done) begin
					boot_next = BOOT_RUN;
				end
			end
			// stays here until the next reset
			BOOT_RUN: boot_next = BOOT_RUN;
			default: boot_next = BOOT_RESET;
		endcase
	end

	assign copy_reset = (boot_state == BOOT_RESET);
	assign booting    = (boot_state == BOOT_COPY);
	assign running    = (boot_state == BOOT_RUN);

	// ----------------------------------------
	// access state machine
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			acc_state <= ACC_IDLE;
		end else begin
			acc_state <= acc_next;
		end
	end

	always_comb begin
		acc_next = acc_state;
		case (acc_state)
			ACC_IDLE: begin
				// requests wait until the copy is over
				if (running && mem_valid) begin
					acc_next = mem_write ? ACC_WRITE_PREP : ACC_READ_WAIT;
				end
			end
			ACC_READ_WAIT: begin
				if (wait_done) begin
					acc_next = ACC_IDLE;
				end
			end
			ACC_WRITE_PREP: acc_next = ACC_WRITE;
			ACC_WRITE: begin
				// a write ends with a read back of the same word
				if (wait_done) begin
					acc_next = ACC_READ_WAIT;
				end
			end
			default: acc_next = ACC_IDLE;
		endcase
	end

	assign count_read  = (acc_state == ACC_READ_WAIT);
	assign count_write = (acc_state == ACC_WRITE);

	// RAM word is valid by the last read wait cycle
	assign mem_ready = count_read && wait_done;

	// ----------------------------------------
	// write data and watch register
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (acc_state == ACC_WRITE_PREP) begin
			write_data <= mem_wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			watch_data <= '0;
		end else if (acc_state == ACC_WRITE_PREP && mem_addr == WATCH_ADDR) begin
			watch_data <= mem_wdata;
		end
	end

	// ----------------------------------------
	// RAM port steering
	// ----------------------------------------
	always_comb begin
		case (boot_state)
			BOOT_RUN: begin
				ram_we    = (acc_state == ACC_WRITE);
				ram_addr  = mem_addr;
				ram_wdata = write_data;
			end
			BOOT_COPY: begin
				ram_we    = copy_we;
				ram_addr  = copy_addr;
				ram_wdata = copy_data;
			end
			default: begin
				// no writes while the copier is cleared
				ram_we    = 1'b0;
				ram_addr  = copy_addr;
				ram_wdata = copy_data;
			end
		endcase
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	a_ready_when_running : assert property (
		@(posedge clock) disable iff (reset)
		mem_ready |-> running
	);

	// requester holds the address until served
	a_addr_held : assert property (
		@(posedge clock) disable iff (reset)
		(mem_valid && !mem_ready) |=> $stable(mem_addr)
	);

endmodule

// File: logic/cpu_mem_ctrl.sv
// processor memory controller, top level
// copies the boot ROM into RAM after reset, then serves
// processor reads and writes with wait states

module cpu_mem_ctrl import memctl_pkg::*; #(
	parameter int unsigned ROM_WORDS  = 64,
	parameter int unsigned READ_WAIT  = 1,
	parameter int unsigned WRITE_WAIT = 2,
	parameter addr_t       WATCH_ADDR = 8'hff
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  mem_valid,
	input  logic  mem_write,
	input  addr_t mem_addr,
	input  data_t mem_wdata,
	output logic  mem_ready,
	output data_t mem_rdata,
	output logic  booting,
	output logic  running,
	output data_t watch_data
);

	// ROM and copier
	addr_t rom_addr;
	data_t rom_data;
	logic  copy_reset;
	logic  copy_we;
	addr_t copy_addr;
	data_t copy_data;
	logic  copy_done;

	// RAM port
	logic  ram_we;
	addr_t ram_addr;
	data_t ram_wdata;

	// wait states
	logic count_read;
	logic count_write;
	logic wait_done;

	// ----------------------------------------
	// instances
	// ----------------------------------------
	boot_rom #(.ROM_WORDS(ROM_WORDS)) u_rom (
		.rom_addr(rom_addr), .rom_data(rom_data)
	);

	rom_copier #(.ROM_WORDS(ROM_WORDS)) u_copier (
		.clock(clock), .copy_reset(copy_reset),
		.rom_addr(rom_addr), .rom_data(rom_data),
		.copy_we(copy_we), .copy_addr(copy_addr),
		.copy_data(copy_data), .copy_done(copy_done)
	);

	// read data goes straight out to the processor
	sys_ram u_ram (
		.clock(clock), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_rdata(mem_rdata)
	);

	wait_counter #(.READ_WAIT(READ_WAIT), .WRITE_WAIT(WRITE_WAIT)) u_wait (
		.clock(clock), .reset(reset), .count_read(count_read),
		.count_write(count_write), .wait_done(wait_done)
	);

	mem_sequencer #(.WATCH_ADDR(WATCH_ADDR)) u_seq (
		.clock(clock), .reset(reset),
		.copy_reset(copy_reset), .copy_we(copy_we), .copy_addr(copy_addr),
		.copy_data(copy_data), .copy_done(copy_done),
		.mem_valid(mem_valid), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ready(mem_ready),
		.ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.count_read(count_read), .count_write(count_write), .wait_done(wait_done),
		.booting(booting), .running(running), .watch_data(watch_data)
	);

endmodule

// File: verif/cpu_mem_ctrl_tb.sv
// testbench for the processor memory controller
// plays the processor on the memory port and checks the boot copy,
// wait-state reads and writes, the watch register and reset recovery

module cpu_mem_ctrl_tb import memctl_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned ROM_WORDS  = 64;
	localparam int unsigned READ_WAIT  = 1;
	localparam int unsigned WRITE_WAIT = 2;
	localparam addr_t       WATCH_ADDR = 8'hff;
	localparam int          RANDOM_OPS = 200;

	// longest access plus handshake slack
	localparam int ACCESS_CYCLES = WRITE_WAIT + READ_WAIT + 8;
	localparam int BOOT_CYCLES   = ROM_WORDS + 16;
	// requests issued by all tests together
	localparam int TOTAL_REQUESTS  = 3 * ROM_WORDS + RANDOM_OPS + 20;
	localparam int WATCHDOG_CYCLES = 2 * (TOTAL_REQUESTS * ACCESS_CYCLES + 4 * BOOT_CYCLES);

	logic  clock;
	logic  reset;
	logic  mem_valid;
	logic  mem_write;
	addr_t mem_addr;
	data_t mem_wdata;
	logic  mem_ready;
	data_t mem_rdata;
	logic  booting;
	logic  running;
	data_t watch_data;

	// expected RAM contents, known flags and watch value
	data_t       model_mem [256];
	logic        model_known [256];
	data_t       watch_expected;
	logic [31:0] lcg_state;
	int          error_count;
	int          check_count;
	int          test_count;

	cpu_mem_ctrl #(
		.ROM_WORDS(ROM_WORDS), .READ_WAIT(READ_WAIT),
		.WRITE_WAIT(WRITE_WAIT), .WATCH_ADDR(WATCH_ADDR)
	) u_dut (
		.clock(clock), .reset(reset), .mem_valid(mem_valid), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
		.mem_rdata(mem_rdata), .booting(booting), .running(running),
		.watch_data(watch_data)
	);

	// 20 ns clock
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("CHECK FAILED %s expected %h actual %h", test_name, expected, actual);
		end
	endtask

	task automatic report_error(input string text);
		error_count++;
		$display("ERROR %s", text);
	endtask

	task automatic finish_test(input string test_name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, error_count - errors_before);
		end
	endtask

	// image region back to the boot image
	// RAM above the image keeps its words
	function automatic void reset_model();
		for (int a = 0; a < ROM_WORDS; a++) begin
			model_mem[a]   = boot_image_word(addr_t'(a));
			model_known[a] = 1'b1;
		end
		watch_expected = '0;
	endfunction

	task automatic apply_reset();
		@(negedge clock);
		reset     = 1'b1;
		mem_valid = 1'b0;
		mem_write = 1'b0;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		reset_model();
	endtask

	// wait for running and note whether the copy phase was seen
	task automatic wait_boot(output bit saw_booting);
		int waited;
		waited      = 0;
		saw_booting = 1'b0;
		while (!running && waited < BOOT_CYCLES) begin
			@(negedge clock);
			waited++;
			if (booting) begin
				saw_booting = 1'b1;
			end
		end
		if (!running) begin
			report_error("running did not rise after reset");
		end else begin
			check_value("boot", 0, booting);
		end
	endtask

	// ----------------------------------------
	// processor port
	// ----------------------------------------
	// drive one request and hold it until mem_ready
	task automatic access(input string test_name, input logic write, input addr_t addr,
		input data_t wdata, input int limit, output data_t rdata);
		int waited;
		waited = 0;
		@(negedge clock);
		mem_valid = 1'b1;
		mem_write = write;
		mem_addr  = addr;
		mem_wdata = wdata;
		do begin
			@(negedge clock);
			waited++;
			if (mem_ready && !running) begin
				report_error($sformatf("%s: mem_ready seen before running", test_name));
			end
		end while (!mem_ready && waited < limit);
		if (!mem_ready) begin
			report_error($sformatf("%s: no mem_ready within %0d cycles", test_name, limit));
		end
		rdata = mem_rdata;
		// ready cycle ends at the next rising edge
		@(negedge clock);
		mem_valid = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic do_write(input string test_name, input addr_t addr, input data_t data);
		data_t rdata;
		access(test_name, 1'b1, addr, data, ACCESS_CYCLES, rdata);
		model_mem[addr]   = data;
		model_known[addr] = 1'b1;
		if (addr == WATCH_ADDR) begin
			watch_expected = data;
		end
		// write completes with the word read back
		check_value(test_name, data, rdata);
		check_value(test_name, watch_expected, watch_data);
	endtask

	task automatic do_read(input string test_name, input addr_t addr);
		data_t rdata;
		access(test_name, 1'b0, addr, '0, ACCESS_CYCLES, rdata);
		if (model_known[addr]) begin
			check_value(test_name, model_mem[addr], rdata);
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_boot_image(input bit saw_booting);
		int errors_before;
		errors_before = error_count;
		check_value("boot_image", 1, saw_booting);
		for (int a = 0; a < ROM_WORDS; a++) begin
			do_read("boot_image", addr_t'(a));
		end
		finish_test("boot_image", errors_before);
	endtask

	task automatic test_write_read();
		int errors_before;
		errors_before = error_count;
		do_write("write_read", 8'h20, 8'h5a);
		do_read("write_read", 8'h20);
		// neighbours keep the image
		do_read("write_read", 8'h21);
		do_read("write_read", 8'h1f);
		finish_test("write_read", errors_before);
	endtask

	task automatic test_watch_register();
		int errors_before;
		errors_before = error_count;
		do_write("watch_register", WATCH_ADDR, 8'h3c);
		check_value("watch_register", 8'h3c, watch_data);
		do_write("watch_register", WATCH_ADDR - 8'd1, 8'h77);
		do_write("watch_register", 8'h10, 8'he1);
		check_value("watch_register", 8'h3c, watch_data);
		do_write("watch_register", WATCH_ADDR, 8'h81);
		check_value("watch_register", 8'h81, watch_data);
		finish_test("watch_register", errors_before);
	endtask

	task automatic test_random_traffic();
		int          errors_before;
		logic [31:0] r;
		errors_before = error_count;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			r = lcg_next();
			// address and data from the upper bits
			// low LCG bits repeat too soon
			if (r[31]) begin
				do_write("random_traffic", addr_t'(r[23:16]), data_t'(r[15:8]));
			end else begin
				do_read("random_traffic", addr_t'(r[23:16]));
			end
		end
		finish_test("random_traffic", errors_before);
	endtask

	task automatic test_reset_mid_run();
		int errors_before;
		bit saw_booting;
		errors_before = error_count;
		do_write("reset_mid_run", 8'h00, 8'h11);
		do_write("reset_mid_run", addr_t'(ROM_WORDS - 1), 8'h22);
		do_write("reset_mid_run", WATCH_ADDR, 8'h99);
		apply_reset();
		wait_boot(saw_booting);
		check_value("reset_mid_run", 1, saw_booting);
		check_value("reset_mid_run", 0, watch_data);
		for (int a = 0; a < ROM_WORDS; a++) begin
			do_read("reset_mid_run", addr_t'(a));
		end
		finish_test("reset_mid_run", errors_before);
	endtask

	task automatic test_request_during_boot();
		int    errors_before;
		int    waited;
		data_t rdata;
		errors_before = error_count;
		waited        = 0;
		apply_reset();
		while (!booting && waited < BOOT_CYCLES) begin
			@(negedge clock);
			waited++;
		end
		check_value("request_during_boot", 1, booting);
		// raised mid copy and served only once running
		access("request_during_boot", 1'b0, 8'h05, '0, BOOT_CYCLES + ACCESS_CYCLES, rdata);
		check_value("request_during_boot", 1, running);
		check_value("request_during_boot", boot_image_word(8'h05), rdata);
		finish_test("request_during_boot", errors_before);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		bit saw_booting;
		reset       = 1'b1;
		mem_valid   = 1'b0;
		mem_write   = 1'b0;
		mem_addr    = '0;
		mem_wdata   = '0;
		lcg_state   = 32'h3b6f;
		error_count = 0;
		check_count = 0;
		test_count  = 0;
		for (int a = 0; a < 256; a++) begin
			model_mem[a]   = '0;
			model_known[a] = 1'b0;
		end
		apply_reset();
		wait_boot(saw_booting);
		test_boot_image(saw_booting);
		test_write_read();
		test_watch_register();
		test_random_traffic();
		test_reset_mid_run();
		test_request_during_boot();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// run limit from request count and boot time
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: filelist.f
logic/memctl_pkg.sv
logic/boot_rom.sv
logic/sys_ram.sv
logic/rom_copier.sv
logic/wait_counter.sv
logic/mem_sequencer.sv
logic/cpu_mem_ctrl.sv
verif/cpu_mem_ctrl_tb.sv
